// File: vlog.f
rtl/pmu_pkg.sv
rtl/frame_receiver.sv
rtl/ack_generator.sv
rtl/pmu_i2c.sv
rtl/pmu_int.sv
rtl/pmu_ctrl_top.sv
verif/i2c_pmu_model.sv
verif/tb_pmu_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_pmu_ctrl
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert -j 0
PASS_MSG ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/tb_pmu_ctrl.sv
`timescale 1ns/10ps

module tb_pmu_ctrl;

	localparam logic [7:0] WR_FRAME = 8'h70;
	localparam logic [7:0] RD_FRAME = 8'h50;
	localparam int TIMEOUT = 8000;

	logic       clk;
	logic       reset;
	logic [7:0] in_addr;
	logic [7:0] in_data;
	logic       in_data_valid;
	logic       in_frame_valid;
	logic       overflow;
	logic [7:0] out_data;
	logic       out_data_valid;
	logic       out_frame_valid;
	logic       out_request;
	logic       out_grant;
	logic       scl_oe;
	logic       sda_oe;
	logic       sda_in;
	logic       ack_en;
	logic       auto_grant;

	logic [15:0] lfsr;
	logic [7:0]  exp_regs [256];
	logic [2:0]  en_ref;
	// Expected frame fields are the data check flag, length, eid, code and data
	logic [26:0] exp_q [$];
	logic [7:0]  rx_bytes [$];
	int          frames_seen;
	int          ovf_count;
	int          sent;

	pmu_ctrl_top #(.WR_FRAME_ADDR(WR_FRAME), .RD_FRAME_ADDR(RD_FRAME), .CLK_DIV(4)) DUT (
		.clk(clk), .reset(reset), .in_addr(in_addr), .in_data(in_data),
		.in_data_valid(in_data_valid), .in_frame_valid(in_frame_valid),
		.overflow(overflow), .out_data(out_data), .out_data_valid(out_data_valid),
		.out_frame_valid(out_frame_valid), .out_request(out_request),
		.out_grant(out_grant), .scl_oe(scl_oe), .sda_oe(sda_oe), .sda_in(sda_in)
	);

	i2c_pmu_model pmu_model (
		.clk(clk), .reset(reset), .scl_oe(scl_oe), .sda_oe(sda_oe),
		.ack_en(ack_en), .sda_in(sda_in)
	);

	always #4 clk = ~clk;

	always @(negedge clk)
		out_grant = auto_grant && out_request;

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] r;
		logic       fb;
		r = 8'd0;
		for (int k = 0; k < n; k++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = {r[6:0], fb};
		end
		return r;
	endfunction

	function automatic logic [7:0] rail_reg(input logic [7:0] idx);
		if (idx == 8'd0)
			return 8'h32;
		else if (idx == 8'd1)
			return 8'h26;
		return 8'h29;
	endfunction

	// Updates the expected register image and returns the expected response frame
	function automatic logic [26:0] expected_response(input logic query, input logic [7:0] eid,
			input logic [7:0] param, input logic [7:0] idx, input logic [7:0] val,
			input logic acked);
		logic [7:0] sub;
		logic [7:0] value;
		logic [7:0] code;
		logic [7:0] data;
		sub = (param == 8'h76) ? rail_reg(idx) : 8'h10;
		code = acked ? 8'h06 : 8'h15;
		if (!query) begin
			if (param != 8'h76 && idx < 8'd3)
				en_ref[idx[1:0]] = val[0];
			if (param == 8'h76)
				value = {3'b000, val[4:0]};
			else
				value = {3'b100, en_ref[0], 1'b1, en_ref[2], en_ref[1], 1'b1};
			if (acked) begin
				exp_regs[sub] = value;
				exp_regs[8'h20] = 8'h55;
			end
			return {1'b0, 2'd2, eid, code, 8'h00};
		end
		data = exp_regs[sub];
		if (param != 8'h76) begin
			if (idx == 8'd0)
				data = {7'd0, data[4]};
			else if (idx == 8'd1)
				data = {7'd0, data[1]};
			else
				data = {7'd0, data[2]};
		end
		return {acked, 2'd3, eid, code, data};
	endfunction

	task automatic stop_with_fail();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic report_err(input string msg);
		$display("ERR %0t: %s", $time, msg);
		stop_with_fail();
	endtask

	task automatic compare_frame();
		logic [26:0] e;
		assert (exp_q.size() != 0) begin
			e = exp_q.pop_front();
			assert (rx_bytes.size() == int'(e[25:24]))
				else report_err($sformatf("frame has %0d bytes, expected %0d",
					rx_bytes.size(), e[25:24]));
			assert (rx_bytes[0] == e[23:16])
				else report_err($sformatf("eid %02h, expected %02h", rx_bytes[0], e[23:16]));
			assert (rx_bytes[1] == e[15:8])
				else report_err($sformatf("code %02h, expected %02h", rx_bytes[1], e[15:8]));
			if (e[26]) begin
				assert (rx_bytes[2] == e[7:0])
					else report_err($sformatf("data %02h, expected %02h", rx_bytes[2], e[7:0]));
			end
		end else begin
			$display("A response frame arrived that no command asked for");
			stop_with_fail();
		end
	endtask

	always @(posedge clk) begin
		if (!reset) begin
			if (overflow)
				ovf_count++;
			// Every response byte travels inside the frame envelope and nowhere else
			assert (out_frame_valid == out_data_valid)
				else report_err($sformatf("out_frame_valid %0b with out_data_valid %0b",
					out_frame_valid, out_data_valid));
			if (out_data_valid) begin
				rx_bytes.push_back(out_data);
			end else if (rx_bytes.size() != 0) begin
				compare_frame();
				rx_bytes.delete();
				frames_seen++;
			end
		end
	end

	task automatic send_frame(input logic [7:0] addr, input int n, input logic [7:0] b0,
			input logic [7:0] b1, input logic [7:0] b2, input logic [7:0] b3);
		logic [7:0] b [4];
		b[0] = b0;
		b[1] = b1;
		b[2] = b2;
		b[3] = b3;
		in_frame_valid = 1'b1;
		in_addr = addr;
		for (int k = 0; k < n; k++) begin
			in_data = b[k[1:0]];
			in_data_valid = 1'b1;
			@(negedge clk);
		end
		in_data_valid = 1'b0;
		in_frame_valid = 1'b0;
		in_addr = 8'h00;
		repeat (2) @(negedge clk);
	endtask

	task automatic issue_write(input logic [7:0] eid, input logic [7:0] param,
			input logic [7:0] idx, input logic [7:0] val);
		exp_q.push_back(expected_response(1'b0, eid, param, idx, val, ack_en));
		send_frame(WR_FRAME, 4, eid, param, idx, val);
		sent++;
	endtask

	task automatic issue_query(input logic [7:0] eid, input logic [7:0] param,
			input logic [7:0] idx);
		exp_q.push_back(expected_response(1'b1, eid, param, idx, 8'h00, ack_en));
		send_frame(RD_FRAME, 3, eid, param, idx, 8'h00);
		sent++;
	endtask

	task automatic wait_frames(input int target);
		int cycles;
		cycles = 0;
		while (frames_seen < target && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (frames_seen < target) begin
			$display("Timed out waiting for response frame number %0d", target);
			stop_with_fail();
		end
	endtask

	task automatic wait_request();
		int cycles;
		cycles = 0;
		while (!out_request && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!out_request) begin
			$display("Timed out waiting for the response bus request");
			stop_with_fail();
		end
	endtask

	task automatic wait_overflow(input int target);
		int cycles;
		cycles = 0;
		while (ovf_count < target && cycles < 50) begin
			@(negedge clk);
			cycles++;
		end
		if (ovf_count < target) begin
			$display("Timed out waiting for the overflow pulse");
			stop_with_fail();
		end
	endtask

	task automatic check_regs();
		for (int i = 0; i < 256; i++) begin
			assert (pmu_model.regs[i[7:0]] === exp_regs[i[7:0]])
				else report_err($sformatf("register %02h is %02h, expected %02h", i,
					pmu_model.regs[i[7:0]], exp_regs[i[7:0]]));
		end
	endtask

	task automatic check_quiet(input int window);
		for (int c = 0; c < window; c++) begin
			@(negedge clk);
			assert (!out_request && !out_frame_valid)
				else report_err("response started for a frame that should be dropped");
		end
	endtask

	task automatic pick_rail(output logic [7:0] idx);
		idx = rand_bits(2);
		if (idx == 8'd3)
			idx = 8'd2;
	endtask

	initial begin
		logic [7:0] idx;
		logic [7:0] pat;
		clk = 1'b0;
		reset = 1'b1;
		in_addr = 8'h00;
		in_data = 8'h00;
		in_data_valid = 1'b0;
		in_frame_valid = 1'b0;
		out_grant = 1'b0;
		ack_en = 1'b1;
		auto_grant = 1'b1;
		lfsr = 16'd27839;
		en_ref = 3'd0;
		frames_seen = 0;
		ovf_count = 0;
		sent = 0;
		pat = 8'he1;
		for (int i = 0; i < 256; i++) begin
			exp_regs[i[7:0]] = pat;
			pat = {pat[6:0], pat[7] ^ pat[5] ^ pat[4] ^ pat[3]};
		end
		repeat (2) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		for (int n = 0; n < 6; n++) begin
			pick_rail(idx);
			issue_write(rand_bits(8), 8'h76, idx, rand_bits(8));
			wait_frames(sent);
			check_regs();
		end
		for (int n = 0; n < 6; n++) begin
			pick_rail(idx);
			issue_write(rand_bits(8), 8'h01, idx, rand_bits(8));
			wait_frames(sent);
			check_regs();
		end
		for (int n = 0; n < 8; n++) begin
			pick_rail(idx);
			issue_query(rand_bits(8), rand_bits(1) ? 8'h76 : 8'h01, idx);
			wait_frames(sent);
		end

		// Missing acknowledge from the PMU
		ack_en = 1'b0;
		issue_write(8'ha1, 8'h76, 8'd0, 8'h1f);
		wait_frames(sent);
		issue_query(8'ha2, 8'h76, 8'd1);
		wait_frames(sent);
		ack_en = 1'b1;
		issue_query(8'ha3, 8'h01, 8'd0);
		wait_frames(sent);

		// One frame pends under back-pressure and the next one overflows
		auto_grant = 1'b0;
		issue_write(8'hb1, 8'h76, 8'd0, 8'h0a);
		wait_request();
		issue_write(8'hb2, 8'h76, 8'd2, 8'h0b);
		// The dropped write would change every low bit of the rail 1 register
		send_frame(WR_FRAME, 4, 8'hb3, 8'h76, 8'd1, exp_regs[8'h26] ^ 8'h1f);
		wait_overflow(1);
		repeat (20) @(negedge clk);
		auto_grant = 1'b1;
		wait_frames(sent);
		check_regs();

		// Bad byte counts and a foreign address
		send_frame(WR_FRAME, 3, 8'hc1, 8'h76, 8'd0, 8'h00);
		send_frame(RD_FRAME, 4, 8'hc2, 8'h76, 8'd0, 8'h00);
		send_frame(8'h33, 4, 8'hc3, 8'h76, 8'd1, 8'h07);
		check_quiet(2000);
		check_regs();

		if (frames_seen == sent && exp_q.size() == 0 && ovf_count == 1) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("Run ended with %0d of %0d frames and %0d overflow pulses",
				frames_seen, sent, ovf_count);
			stop_with_fail();
		end
	end

endmodule

// File: verif/i2c_pmu_model.sv
`timescale 1ns/10ps

module i2c_pmu_model (
	input  logic clk,
	input  logic reset,
	input  logic scl_oe,
	input  logic sda_oe,
	input  logic ack_en,
	output logic sda_in
);

	typedef enum logic [2:0] {
		M_IDLE,
		M_ADDR,
		M_SUB,
		M_WDATA,
		M_READ
	} model_state_t;

	model_state_t state;
	logic [7:0] regs [256];
	logic [7:0] ptr;
	logic [7:0] shreg;
	logic [7:0] tx;
	logic [3:0] bitcnt;
	logic       acking;
	logic       drive_low;
	logic       scl;
	logic       sda;
	logic       scl_q;
	logic       sda_q;
	logic [7:0] pat;

	// Open-drain lines with pull-ups, so any driver pulling low wins
	assign scl = !scl_oe;
	assign sda = !(sda_oe || drive_low);
	assign sda_in = sda;

	initial begin
		pat = 8'he1;
		for (int i = 0; i < 256; i++) begin
			regs[i[7:0]] = pat;
			pat = {pat[6:0], pat[7] ^ pat[5] ^ pat[4] ^ pat[3]};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= M_IDLE;
			bitcnt <= 4'd0;
			acking <= 1'b0;
			drive_low <= 1'b0;
			scl_q <= 1'b1;
			sda_q <= 1'b1;
		end else begin
			scl_q <= scl;
			sda_q <= sda;
			if (scl && scl_q && sda_q && !sda) begin
				// Start or repeated start
				state <= M_ADDR;
				bitcnt <= 4'd0;
				acking <= 1'b0;
				drive_low <= 1'b0;
			end else if (scl && scl_q && !sda_q && sda) begin
				state <= M_IDLE;
				acking <= 1'b0;
				drive_low <= 1'b0;
			end else if (scl && !scl_q && state != M_IDLE) begin
				if (bitcnt == 4'd8) begin
					bitcnt <= 4'd0;
					// A NACK from the master ends the read
					if (state == M_READ && sda)
						state <= M_IDLE;
				end else begin
					bitcnt <= bitcnt + 4'd1;
					if (state != M_READ)
						shreg <= {shreg[6:0], sda};
				end
			end else if (!scl && scl_q && state != M_IDLE) begin
				if (acking) begin
					acking <= 1'b0;
					drive_low <= (state == M_READ) ? !tx[7] : 1'b0;
					if (state == M_READ)
						tx <= {tx[6:0], 1'b1};
				end else if (state == M_READ) begin
					drive_low <= (bitcnt < 4'd8) ? !tx[7] : 1'b0;
					tx <= {tx[6:0], 1'b1};
				end else if (bitcnt == 4'd8) begin
					if (!ack_en || (state == M_ADDR && shreg[7:1] != 7'h68)) begin
						state <= M_IDLE;
					end else begin
						drive_low <= 1'b1;
						acking <= 1'b1;
						case (state)
							M_ADDR: begin
								state <= shreg[0] ? M_READ : M_SUB;
								tx <= regs[ptr];
							end
							M_SUB: begin
								ptr <= shreg;
								state <= M_WDATA;
							end
							default: begin
								regs[ptr] <= shreg;
								ptr <= ptr + 8'd1;
							end
						endcase
					end
				end
			end
		end
	end

endmodule

// File: rtl/pmu_ctrl_top.sv
`timescale 1ns/10ps

module pmu_ctrl_top #(
	parameter logic [7:0] WR_FRAME_ADDR = 8'h70,
	parameter logic [7:0] RD_FRAME_ADDR = 8'h50,
	parameter int CLK_DIV = 4
) (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] in_addr,
	input  logic [7:0] in_data,
	input  logic       in_data_valid,
	input  logic       in_frame_valid,
	output logic       overflow,
	output logic [7:0] out_data,
	output logic       out_data_valid,
	output logic       out_frame_valid,
	output logic       out_request,
	input  logic       out_grant,
	output logic       scl_oe,
	output logic       sda_oe,
	input  logic       sda_in
);

	logic              wr_valid, wr_take, wr_overflow;
	logic [7:0]        wr_eid, wr_param, wr_idx, wr_val;
	logic              rd_valid, rd_take, rd_overflow;
	logic [7:0]        rd_eid, rd_param, rd_idx;
	pmu_pkg::i2c_cmd_t i2c_cmd;
	logic [7:0]        i2c_tx, rx_byte;
	logic              i2c_valid, i2c_ready, nack, clear_nack;
	logic              resp_start, resp_ok, resp_has_data, resp_done;
	logic [7:0]        resp_eid, resp_data;

	frame_receiver #(.MATCH_ADDR(WR_FRAME_ADDR), .NUM_BYTES(4)) wr_rx (
		.clk(clk), .reset(reset), .in_addr(in_addr), .in_data(in_data),
		.in_data_valid(in_data_valid), .in_frame_valid(in_frame_valid),
		.cmd_take(wr_take), .cmd_valid(wr_valid), .cmd_eid(wr_eid),
		.cmd_param(wr_param), .cmd_idx(wr_idx), .cmd_val(wr_val),
		.overflow(wr_overflow)
	);

	// Queries carry no value byte
	frame_receiver #(.MATCH_ADDR(RD_FRAME_ADDR), .NUM_BYTES(3)) rd_rx (
		.clk(clk), .reset(reset), .in_addr(in_addr), .in_data(in_data),
		.in_data_valid(in_data_valid), .in_frame_valid(in_frame_valid),
		.cmd_take(rd_take), .cmd_valid(rd_valid), .cmd_eid(rd_eid),
		.cmd_param(rd_param), .cmd_idx(rd_idx), .cmd_val(),
		.overflow(rd_overflow)
	);

	pmu_int ctrl (
		.clk(clk), .reset(reset),
		.wr_valid(wr_valid), .wr_eid(wr_eid), .wr_param(wr_param),
		.wr_idx(wr_idx), .wr_val(wr_val),
		.rd_valid(rd_valid), .rd_eid(rd_eid), .rd_param(rd_param), .rd_idx(rd_idx),
		.wr_overflow(wr_overflow), .rd_overflow(rd_overflow),
		.wr_take(wr_take), .rd_take(rd_take), .overflow(overflow),
		.i2c_cmd(i2c_cmd), .i2c_tx(i2c_tx), .i2c_valid(i2c_valid),
		.i2c_ready(i2c_ready), .rx_byte(rx_byte), .nack(nack), .clear_nack(clear_nack),
		.resp_start(resp_start), .resp_eid(resp_eid), .resp_ok(resp_ok),
		.resp_has_data(resp_has_data), .resp_data(resp_data), .resp_done(resp_done)
	);

	pmu_i2c #(.CLK_DIV(CLK_DIV)) i2c (
		.clk(clk), .reset(reset), .i2c_cmd(i2c_cmd), .i2c_tx(i2c_tx),
		.i2c_valid(i2c_valid), .i2c_ready(i2c_ready), .rx_byte(rx_byte),
		.nack(nack), .clear_nack(clear_nack),
		.scl_oe(scl_oe), .sda_oe(sda_oe), .sda_in(sda_in)
	);

	ack_generator ackgen (
		.clk(clk), .reset(reset), .resp_start(resp_start), .resp_eid(resp_eid),
		.resp_ok(resp_ok), .resp_has_data(resp_has_data), .resp_data(resp_data),
		.resp_done(resp_done), .out_request(out_request), .out_grant(out_grant),
		.out_data(out_data), .out_data_valid(out_data_valid),
		.out_frame_valid(out_frame_valid)
	);

endmodule

// File: rtl/pmu_int.sv
`timescale 1ns/10ps

module pmu_int (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  wr_valid,
	input  logic [7:0]            wr_eid,
	input  logic [7:0]            wr_param,
	input  logic [7:0]            wr_idx,
	input  logic [7:0]            wr_val,
	input  logic                  rd_valid,
	input  logic [7:0]            rd_eid,
	input  logic [7:0]            rd_param,
	input  logic [7:0]            rd_idx,
	input  logic                  wr_overflow,
	input  logic                  rd_overflow,
	output logic                  wr_take,
	output logic                  rd_take,
	output logic                  overflow,
	output pmu_pkg::i2c_cmd_t     i2c_cmd,
	output logic [7:0]            i2c_tx,
	output logic                  i2c_valid,
	input  logic                  i2c_ready,
	input  logic [7:0]            rx_byte,
	input  logic                  nack,
	output logic                  clear_nack,
	output logic                  resp_start,
	output logic [7:0]            resp_eid,
	output logic                  resp_ok,
	output logic                  resp_has_data,
	output logic [7:0]            resp_data,
	input  logic                  resp_done
);

	pmu_pkg::ctrl_state_t state;
	logic [7:0] eid_q;
	logic [7:0] idx_q;
	logic [7:0] val_q;
	logic [7:0] rd_byte_q;
	logic       is_volt;
	logic       is_query;
	logic       slew;
	logic       start_sent;
	logic [2:0] en_img;
	logic [7:0] subaddr;
	logic [7:0] wr_value;
	logic       en_bit;
	logic       accepted;

	// Writes win over queries when both are pending
	assign wr_take = (state == pmu_pkg::IDLE) && wr_valid;
	assign rd_take = (state == pmu_pkg::IDLE) && !wr_valid && rd_valid;
	assign clear_nack = wr_take || rd_take;
	assign overflow = wr_overflow | rd_overflow;
	assign accepted = i2c_valid && i2c_ready;

	assign subaddr = slew ? pmu_pkg::SUBADDR_SLEW :
		is_volt ? pmu_pkg::rail_subaddr(idx_q) : pmu_pkg::SUBADDR_EN;
	// Enable register layout: fixed bits interleaved with the three rail enables
	assign wr_value = slew ? pmu_pkg::SLEW_VAL :
		is_volt ? {3'b000, val_q[4:0]} :
		{3'b100, en_img[0], 1'b1, en_img[2:1], 1'b1};

	always_comb begin
		case (idx_q)
			8'd0: en_bit = rd_byte_q[4];
			8'd1: en_bit = rd_byte_q[1];
			default: en_bit = rd_byte_q[2];
		endcase
	end

	// Response goes out once the STOP has finished on the bus
	assign resp_start = (state == pmu_pkg::RESPOND) && i2c_ready;
	assign resp_eid = eid_q;
	assign resp_ok = !nack;
	assign resp_has_data = is_query;
	assign resp_data = is_volt ? rd_byte_q : {7'd0, en_bit};

	always_comb begin
		i2c_valid = 1'b0;
		i2c_cmd = pmu_pkg::WRITE;
		i2c_tx = subaddr;
		case (state)
			pmu_pkg::WR_ADDR, pmu_pkg::RD_ADDR, pmu_pkg::RD_RESTART: begin
				i2c_valid = 1'b1;
				i2c_cmd = start_sent ? pmu_pkg::WRITE : pmu_pkg::START;
				i2c_tx = {pmu_pkg::PMU_DEV_ADDR, state == pmu_pkg::RD_RESTART};
			end
			pmu_pkg::WR_SUB, pmu_pkg::RD_SUB: i2c_valid = 1'b1;
			pmu_pkg::WR_DATA: begin
				i2c_valid = 1'b1;
				i2c_tx = wr_value;
			end
			pmu_pkg::RD_DATA: begin
				i2c_valid = 1'b1;
				i2c_cmd = pmu_pkg::READ;
			end
			pmu_pkg::WR_STOP, pmu_pkg::RD_STOP: begin
				i2c_valid = 1'b1;
				i2c_cmd = pmu_pkg::STOP;
			end
			default: i2c_valid = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= pmu_pkg::IDLE;
			en_img <= 3'd0;
			start_sent <= 1'b0;
			slew <= 1'b0;
		end else begin
			case (state)
				pmu_pkg::IDLE: begin
					slew <= 1'b0;
					if (wr_take)
						state <= pmu_pkg::WR_ADDR;
					else if (rd_take)
						state <= pmu_pkg::RD_ADDR;
				end
				pmu_pkg::WR_ADDR, pmu_pkg::RD_ADDR, pmu_pkg::RD_RESTART: begin
					if (accepted) begin
						start_sent <= !start_sent;
						if (start_sent && state == pmu_pkg::WR_ADDR)
							state <= pmu_pkg::WR_SUB;
						else if (start_sent && state == pmu_pkg::RD_ADDR)
							state <= pmu_pkg::RD_SUB;
						else if (start_sent)
							state <= pmu_pkg::RD_DATA;
					end
				end
				pmu_pkg::WR_SUB: if (accepted)
					state <= pmu_pkg::WR_DATA;
				pmu_pkg::WR_DATA: if (accepted)
					state <= pmu_pkg::WR_STOP;
				pmu_pkg::WR_STOP: if (accepted)
					state <= slew ? pmu_pkg::RESPOND : pmu_pkg::SLEW;
				pmu_pkg::SLEW: begin
					slew <= 1'b1;
					state <= pmu_pkg::WR_ADDR;
				end
				pmu_pkg::RD_SUB: if (accepted)
					state <= pmu_pkg::RD_RESTART;
				pmu_pkg::RD_DATA: if (accepted)
					state <= pmu_pkg::RD_STOP;
				pmu_pkg::RD_STOP: if (accepted)
					state <= pmu_pkg::RESPOND;
				pmu_pkg::RESPOND: if (i2c_ready)
					state <= pmu_pkg::WAIT_RESP;
				pmu_pkg::WAIT_RESP: if (resp_done)
					state <= pmu_pkg::IDLE;
				default: state <= pmu_pkg::IDLE;
			endcase
			if (wr_take && wr_param != pmu_pkg::PARAM_VOLT && wr_idx < 8'd3)
				en_img[wr_idx[1:0]] <= wr_val[0];
		end
	end

	always_ff @(posedge clk) begin
		if (wr_take) begin
			eid_q <= wr_eid;
			idx_q <= wr_idx;
			val_q <= wr_val;
			is_volt <= (wr_param == pmu_pkg::PARAM_VOLT);
			is_query <= 1'b0;
		end else if (rd_take) begin
			eid_q <= rd_eid;
			idx_q <= rd_idx;
			is_volt <= (rd_param == pmu_pkg::PARAM_VOLT);
			is_query <= 1'b1;
		end
		if (state == pmu_pkg::RD_STOP && accepted)
			rd_byte_q <= rx_byte;
	end

	a_no_overlap: assert property (@(posedge clk) disable iff (reset)
		!(i2c_valid && resp_start))
		else $error("I2C request and response start in the same cycle");

	a_done_waits: assert property (@(posedge clk) disable iff (reset)
		resp_done |-> state == pmu_pkg::WAIT_RESP)
		else $error("response finished while the controller was not waiting");

endmodule

// File: rtl/pmu_i2c.sv
`timescale 1ns/10ps

module pmu_i2c #(
	parameter int CLK_DIV = 4
) (
	input  logic              clk,
	input  logic              reset,
	input  pmu_pkg::i2c_cmd_t i2c_cmd,
	input  logic [7:0]        i2c_tx,
	input  logic              i2c_valid,
	output logic              i2c_ready,
	output logic [7:0]        rx_byte,
	output logic              nack,
	input  logic              clear_nack,
	output logic              scl_oe,
	output logic              sda_oe,
	input  logic              sda_in
);

	localparam int DW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

	pmu_pkg::i2c_cmd_t cmd_q;
	logic              busy;
	logic [DW-1:0]     div_cnt;
	logic [1:0]        quarter;
	logic [3:0]        bit_cnt;
	logic [7:0]        shreg;
	logic              scl_park;
	logic              sda_park;
	logic              tick;
	logic              byte_op;
	logic              last_bit;
	logic              sample;
	logic              bit_end;

	assign tick = busy && (div_cnt == DW'(CLK_DIV - 1));
	assign byte_op = (cmd_q == pmu_pkg::WRITE) || (cmd_q == pmu_pkg::READ);
	// Bit 8 of a byte operation is the acknowledge slot
	assign last_bit = byte_op ? (bit_cnt == 4'd8) : 1'b1;
	// SDA is sampled at the end of the first high quarter of SCL
	assign sample = tick && (quarter == 2'd1);
	assign bit_end = tick && (quarter == 2'd3);
	assign i2c_ready = !busy;
	assign rx_byte = shreg;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			cmd_q <= pmu_pkg::STOP;
			div_cnt <= '0;
			quarter <= 2'd0;
			bit_cnt <= 4'd0;
			scl_park <= 1'b0;
			sda_park <= 1'b0;
			nack <= 1'b0;
		end else begin
			if (i2c_valid && !busy) begin
				busy <= 1'b1;
				cmd_q <= i2c_cmd;
				div_cnt <= '0;
				quarter <= 2'd0;
				bit_cnt <= 4'd0;
			end else if (busy) begin
				div_cnt <= tick ? '0 : div_cnt + DW'(1);
				if (tick)
					quarter <= quarter + 2'd1;
				if (bit_end) begin
					bit_cnt <= bit_cnt + 4'd1;
					if (last_bit) begin
						busy <= 1'b0;
						// SCL stays low between bytes; only STOP frees the bus
						scl_park <= (cmd_q != pmu_pkg::STOP);
						sda_park <= (cmd_q == pmu_pkg::START);
					end
				end
			end
			if (sample && cmd_q == pmu_pkg::WRITE && last_bit && sda_in)
				nack <= 1'b1;
			else if (clear_nack)
				nack <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (i2c_valid && !busy)
			shreg <= i2c_tx;
		else if (cmd_q == pmu_pkg::WRITE && bit_end && !last_bit)
			shreg <= {shreg[6:0], 1'b0};
		else if (cmd_q == pmu_pkg::READ && sample && !last_bit)
			shreg <= {shreg[6:0], sda_in};
	end

	always_comb begin
		scl_oe = scl_park;
		sda_oe = sda_park;
		if (busy) begin
			scl_oe = (quarter == 2'd0) || (quarter == 2'd3);
			case (cmd_q)
				pmu_pkg::START: begin
					// SDA falls while SCL is high, which also covers a repeated start
					sda_oe = quarter[1];
				end
				pmu_pkg::WRITE: sda_oe = !last_bit && !shreg[7];
				pmu_pkg::READ: sda_oe = 1'b0;
				default: begin
					scl_oe = (quarter == 2'd0);
					sda_oe = !quarter[1];
				end
			endcase
		end
	end

endmodule

// File: rtl/ack_generator.sv
`timescale 1ns/10ps

module ack_generator (
	input  logic       clk,
	input  logic       reset,
	input  logic       resp_start,
	input  logic [7:0] resp_eid,
	input  logic       resp_ok,
	input  logic       resp_has_data,
	input  logic [7:0] resp_data,
	output logic       resp_done,
	output logic       out_request,
	input  logic       out_grant,
	output logic [7:0] out_data,
	output logic       out_data_valid,
	output logic       out_frame_valid
);

	typedef enum logic [1:0] {
		AG_IDLE,
		AG_REQ,
		AG_SEND
	} ag_state_t;

	ag_state_t  state;
	logic [1:0] idx;
	logic [7:0] eid_q;
	logic [7:0] data_q;
	logic       ok_q;
	logic       has_data_q;
	logic       last;

	assign last = has_data_q ? (idx == 2'd2) : (idx == 2'd1);
	assign out_request = (state == AG_REQ);
	assign out_frame_valid = (state == AG_SEND);
	assign out_data_valid = (state == AG_SEND);
	assign resp_done = out_data_valid && last;

	always_comb begin
		case (idx)
			2'd0: out_data = eid_q;
			2'd1: out_data = ok_q ? pmu_pkg::ACK_CODE : pmu_pkg::NAK_CODE;
			default: out_data = data_q;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= AG_IDLE;
			idx <= 2'd0;
		end else begin
			case (state)
				AG_IDLE: begin
					idx <= 2'd0;
					if (resp_start)
						state <= AG_REQ;
				end
				AG_REQ: if (out_grant)
					state <= AG_SEND;
				default: begin
					if (last)
						state <= AG_IDLE;
					else
						idx <= idx + 2'd1;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == AG_IDLE && resp_start) begin
			eid_q <= resp_eid;
			ok_q <= resp_ok;
			has_data_q <= resp_data_valid_sel(resp_has_data);
			data_q <= resp_data;
		end
	end

	function automatic logic resp_data_valid_sel(input logic has_data);
		return has_data;
	endfunction

	// Bytes run back to back with the frame envelope until the final one
	a_frame_shape: assert property (@(posedge clk) disable iff (reset)
		out_data_valid && !resp_done |=> out_data_valid && out_frame_valid)
		else $error("gap or missing frame valid inside a response");

	// A new response may only start once the previous frame has gone out
	a_start_idle: assert property (@(posedge clk) disable iff (reset)
		resp_start |-> state == AG_IDLE)
		else $error("response start while a frame is still in flight");

endmodule

// File: rtl/frame_receiver.sv
`timescale 1ns/10ps

module frame_receiver #(
	parameter logic [7:0] MATCH_ADDR = 8'h70,
	parameter int NUM_BYTES = 4
) (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] in_addr,
	input  logic [7:0] in_data,
	input  logic       in_data_valid,
	input  logic       in_frame_valid,
	input  logic       cmd_take,
	output logic       cmd_valid,
	output logic [7:0] cmd_eid,
	output logic [7:0] cmd_param,
	output logic [7:0] cmd_idx,
	output logic [7:0] cmd_val,
	output logic       overflow
);

	logic       frame_q;
	logic       match_q;
	logic [3:0] count;
	logic [7:0] bytes_q [4];
	logic       hit;
	logic       frame_end;
	logic       complete;
	logic       accept;

	assign hit = in_frame_valid && (in_addr == MATCH_ADDR);
	assign frame_end = frame_q && !in_frame_valid;
	assign complete = frame_end && match_q && (count == 4'(NUM_BYTES));
	// A new command lands only if the slot is free or being emptied this cycle
	assign accept = complete && (!cmd_valid || cmd_take);

	always_ff @(posedge clk) begin
		if (reset) begin
			frame_q <= 1'b0;
			match_q <= 1'b0;
			count <= '0;
		end else begin
			frame_q <= in_frame_valid;
			if (in_frame_valid)
				match_q <= hit;
			if (frame_end)
				count <= '0;
			else if (hit && in_data_valid && count != 4'hf)
				count <= count + 4'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (hit && in_data_valid && count < 4'd4)
			bytes_q[count[1:0]] <= in_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cmd_valid <= 1'b0;
			overflow <= 1'b0;
		end else begin
			overflow <= complete && !accept;
			if (accept)
				cmd_valid <= 1'b1;
			else if (cmd_take)
				cmd_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cmd_eid <= bytes_q[0];
			cmd_param <= bytes_q[1];
			cmd_idx <= bytes_q[2];
			cmd_val <= bytes_q[3];
		end
	end

	a_take_pending: assert property (@(posedge clk) disable iff (reset)
		cmd_take |-> cmd_valid)
		else $error("cmd_take with no pending command");

endmodule

// File: rtl/pmu_pkg.sv
package pmu_pkg;

	typedef enum logic [4:0] {
		IDLE,
		WR_ADDR,
		WR_SUB,
		WR_DATA,
		WR_STOP,
		SLEW,
		RESPOND,
		RD_ADDR,
		RD_SUB,
		RD_RESTART,
		RD_DATA,
		RD_STOP,
		WAIT_RESP
	} ctrl_state_t;

	typedef enum logic [1:0] {
		START,
		WRITE,
		READ,
		STOP
	} i2c_cmd_t;

	localparam logic [6:0] PMU_DEV_ADDR = 7'h68;
	localparam logic [7:0] PARAM_VOLT = 8'h76;
	localparam logic [7:0] SUBADDR_EN = 8'h10;
	localparam logic [7:0] SUBADDR_SLEW = 8'h20;
	localparam logic [7:0] SLEW_VAL = 8'h55;
	localparam logic [7:0] ACK_CODE = 8'h06;
	localparam logic [7:0] NAK_CODE = 8'h15;

	// Voltage register of each rail; rails past 1 share the last one
	function automatic logic [7:0] rail_subaddr(input logic [7:0] idx);
		case (idx)
			8'd0: return 8'h32;
			8'd1: return 8'h26;
			default: return 8'h29;
		endcase
	endfunction

endpackage
